/* compile.f */
verilog/ahb_fabric_pkg.sv
verilog/ahb_addr_decoder.sv
verilog/ahb_sram_slave.sv
verilog/ahb_default_slave.sv
verilog/ahb_data_phase_ctrl.sv
verilog/ahb_fabric_top.sv
tb/ahb_fabric_tb.sv

/* tb/ahb_fabric_tb.sv */
// ====================
// pipelined master replaying a table of word transfers
// table reads only target words written earlier in the table
// expected data comes from a reference copy of both srams
// ====================
`timescale 1ns/10ps

module ahb_fabric_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 8;
  // wait states per target
  localparam int SLV0_WAITS     = 0;
  localparam int SLV1_WAITS     = 1;
  localparam int DEFAULT_WAITS  = 1;
  // watchdog budget in cycles per table entry
  localparam int TIMEOUT_FACTOR = 4;

  localparam ahb_fabric_pkg::hresp_t OK  = ahb_fabric_pkg::OKAY;
  localparam ahb_fabric_pkg::hresp_t ERR = ahb_fabric_pkg::ERROR;

  // data phase owner as seen by the master
  localparam int TGT_SLV0    = 0;
  localparam int TGT_SLV1    = 1;
  localparam int TGT_DEFAULT = 2;
  localparam int TGT_NONE    = 3;

  // one table row
  typedef struct packed {
    ahb_fabric_pkg::ahb_addr_t addr;
    ahb_fabric_pkg::htrans_t   htrans;
    logic                      write;
    ahb_fabric_pkg::ahb_data_t wdata;
    ahb_fabric_pkg::hresp_t    resp;
  } entry_t;

  logic                      hclk;
  logic                      rst;
  ahb_fabric_pkg::ahb_req_t  req;
  ahb_fabric_pkg::ahb_data_t hwdata;
  ahb_fabric_pkg::ahb_data_t hrdata;
  logic                      hready;
  ahb_fabric_pkg::hresp_t    hresp;

  entry_t                    table_q [$];
  string                     name_q [$];
  // reference copies of the two srams
  ahb_fabric_pkg::ahb_data_t ref0 [ahb_fabric_pkg::SLV0_WORDS];
  ahb_fabric_pkg::ahb_data_t ref1 [ahb_fabric_pkg::SLV1_WORDS];
  integer                    seed = 32'h5cd2;
  logic                      table_done;
  int                        checks;
  int                        data_errors;
  int                        resp_errors;
  int                        wait_errors;
  int                        ready_errors;

  ahb_fabric_top u_ahb_fabric_top (
    .hclk   (hclk),
    .rst    (rst),
    .req    (req),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready),
    .hresp  (hresp)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  // ====================
  // table helpers
  task automatic add_entry(input string name, input ahb_fabric_pkg::ahb_addr_t addr,
                           input ahb_fabric_pkg::htrans_t htrans, input logic write,
                           input ahb_fabric_pkg::hresp_t resp);
    entry_t e;
    e.addr   = addr;
    e.htrans = htrans;
    e.write  = write;
    // every row gets a fresh word, reads just ignore it
    e.wdata  = $random(seed);
    e.resp   = resp;
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic write_entry(input string name, input ahb_fabric_pkg::ahb_addr_t addr,
                             input ahb_fabric_pkg::hresp_t resp);
    add_entry(name, addr, ahb_fabric_pkg::NONSEQ, 1'b1, resp);
  endtask

  task automatic read_entry(input string name, input ahb_fabric_pkg::ahb_addr_t addr,
                            input ahb_fabric_pkg::hresp_t resp);
    add_entry(name, addr, ahb_fabric_pkg::NONSEQ, 1'b0, resp);
  endtask

  // idle with hwrite set, must not touch memory
  task automatic idle_entry(input string name, input ahb_fabric_pkg::ahb_addr_t addr);
    add_entry(name, addr, ahb_fabric_pkg::IDLE, 1'b1, OK);
  endtask

  task automatic build_table();
    // slave 0, zero wait states
    write_entry("s0 write 2000", 32'h0000_2000, OK);
    write_entry("s0 write 2004", 32'h0000_2004, OK);
    write_entry("s0 write 2010", 32'h0000_2010, OK);
    write_entry("s0 write 23fc", 32'h0000_23FC, OK);
    read_entry("s0 read 2000", 32'h0000_2000, OK);
    read_entry("s0 read 2004", 32'h0000_2004, OK);
    read_entry("s0 read 2010", 32'h0000_2010, OK);
    // slave 1, one wait state
    write_entry("s1 write 2400", 32'h0000_2400, OK);
    write_entry("s1 write 2408", 32'h0000_2408, OK);
    read_entry("s1 read 2408", 32'h0000_2408, OK);
    read_entry("s1 read 2400", 32'h0000_2400, OK);
    // unmapped, 1ffc would alias word 255 of slave 0
    // and 2500 word 0 of slave 1
    write_entry("err write 1ffc", 32'h0000_1FFC, ERR);
    read_entry("err read 2500", 32'h0000_2500, ERR);
    write_entry("err write 2500", 32'h0000_2500, ERR);
    read_entry("err check 2400", 32'h0000_2400, OK);
    read_entry("err check 23fc", 32'h0000_23FC, OK);
    // range edges
    write_entry("bnd write 2000", 32'h0000_2000, OK);
    write_entry("bnd write 23fc", 32'h0000_23FC, OK);
    write_entry("bnd write 2400", 32'h0000_2400, OK);
    write_entry("bnd write 24fc", 32'h0000_24FC, OK);
    read_entry("bnd read 23fc", 32'h0000_23FC, OK);
    read_entry("bnd read 2000", 32'h0000_2000, OK);
    read_entry("bnd read 24fc", 32'h0000_24FC, OK);
    read_entry("bnd read 2400", 32'h0000_2400, OK);
    // mixed owners back to back
    write_entry("mix write 2020", 32'h0000_2020, OK);
    idle_entry("mix idle 2004", 32'h0000_2004);
    write_entry("mix write 2420", 32'h0000_2420, OK);
    read_entry("mix read 3000", 32'h0000_3000, ERR);
    read_entry("mix read 2020", 32'h0000_2020, OK);
    idle_entry("mix idle 2420", 32'h0000_2420);
    read_entry("mix read 2420", 32'h0000_2420, OK);
    write_entry("mix write 0", 32'h0000_0000, ERR);
    read_entry("mix read 2004", 32'h0000_2004, OK);
    read_entry("mix read 24fc", 32'h0000_24FC, OK);
    idle_entry("mix idle 2000", 32'h0000_2000);
  endtask

  // ====================
  // expected behaviour from the address map
  function automatic int target_of(input entry_t e);
    if ((e.htrans != ahb_fabric_pkg::NONSEQ) && (e.htrans != ahb_fabric_pkg::SEQ)) begin
      return TGT_NONE;
    end
    if ((e.addr >= ahb_fabric_pkg::SLV0_LOW) && (e.addr <= ahb_fabric_pkg::SLV0_HIGH)) begin
      return TGT_SLV0;
    end
    if ((e.addr >= ahb_fabric_pkg::SLV1_LOW) && (e.addr <= ahb_fabric_pkg::SLV1_HIGH)) begin
      return TGT_SLV1;
    end
    return TGT_DEFAULT;
  endfunction

  function automatic int waits_for(input int tgt);
    case (tgt)
      TGT_SLV0:    return SLV0_WAITS;
      TGT_SLV1:    return SLV1_WAITS;
      TGT_DEFAULT: return DEFAULT_WAITS;
      default:     return 0;
    endcase
  endfunction

  function automatic ahb_fabric_pkg::ahb_req_t to_req(input entry_t e);
    ahb_fabric_pkg::ahb_req_t r;
    r.haddr  = e.addr;
    r.htrans = e.htrans;
    r.hwrite = e.write;
    return r;
  endfunction

  function automatic ahb_fabric_pkg::ahb_req_t idle_req();
    ahb_fabric_pkg::ahb_req_t r;
    r.haddr  = '0;
    r.htrans = ahb_fabric_pkg::IDLE;
    r.hwrite = 1'b0;
    return r;
  endfunction

  // ====================
  // compare tasks
  task automatic check_data(input string name, input ahb_fabric_pkg::ahb_data_t exp,
                            input ahb_fabric_pkg::ahb_data_t act);
    checks++;
    if (act !== exp) begin
      data_errors++;
      $display("error %s: expected data %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input ahb_fabric_pkg::hresp_t exp,
                            input ahb_fabric_pkg::hresp_t act);
    checks++;
    if (act !== exp) begin
      resp_errors++;
      $display("error %s: expected hresp %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_waits(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      wait_errors++;
      $display("error %s: expected %0d wait cycles, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      ready_errors++;
      $display("error %s: expected hready %b, actual %b", name, exp, act);
    end
  endtask

  // last data phase cycle, called on the falling edge
  task automatic finish_phase(input int idx, input int waits);
    entry_t                    e;
    int                        tgt;
    ahb_fabric_pkg::ahb_data_t exp;
    e   = table_q[idx];
    tgt = target_of(e);
    exp = '0;
    check_waits(name_q[idx], waits_for(tgt), waits);
    if (e.write) begin
      // word index wraps within the sram depth
      if (tgt == TGT_SLV0) begin
        ref0[(e.addr >> 2) % ahb_fabric_pkg::SLV0_WORDS] = e.wdata;
      end else if (tgt == TGT_SLV1) begin
        ref1[(e.addr >> 2) % ahb_fabric_pkg::SLV1_WORDS] = e.wdata;
      end
    end else begin
      if (tgt == TGT_SLV0) begin
        exp = ref0[(e.addr >> 2) % ahb_fabric_pkg::SLV0_WORDS];
      end else if (tgt == TGT_SLV1) begin
        exp = ref1[(e.addr >> 2) % ahb_fabric_pkg::SLV1_WORDS];
      end
      check_data(name_q[idx], exp, hrdata);
    end
  endtask

  // ====================
  // master model
  initial begin : master
    int   cur;
    int   dp;
    int   waits;
    logic accept;
    rst        = 1'b1;
    req        = idle_req();
    hwdata     = '0;
    table_done = 1'b0;
    build_table();
    table_done = 1'b1;
    repeat (RESET_CYCLES) @(posedge hclk);
    rst <= 1'b0;
    @(negedge hclk);
    check_ready("after reset", 1'b1, hready);
    check_resp("after reset", OK, hresp);
    cur   = 0;
    dp    = -1;
    waits = 0;
    @(posedge hclk);
    req <= to_req(table_q[0]);
    while ((cur < table_q.size()) || (dp >= 0)) begin
      // outputs are stable mid cycle
      @(negedge hclk);
      accept = hready && (cur < table_q.size());
      if (dp >= 0) begin
        check_resp(name_q[dp], table_q[dp].resp, hresp);
        if (hready) begin
          finish_phase(dp, waits);
          dp = -1;
        end else begin
          waits++;
        end
      end
      @(posedge hclk);
      // address phase taken on this edge, next one goes out now
      if (accept) begin
        dp     = cur;
        waits  = 0;
        hwdata <= table_q[cur].wdata;
        cur++;
        if (cur < table_q.size()) begin
          req <= to_req(table_q[cur]);
        end else begin
          req <= idle_req();
        end
      end
    end
    $display("summary: %0d checks, %0d data, %0d response, %0d wait, %0d ready errors",
             checks, data_errors, resp_errors, wait_errors, ready_errors);
    if ((data_errors + resp_errors + wait_errors + ready_errors) == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // ====================
  // watchdog
  initial begin : watchdog
    wait (table_done === 1'b1);
    #((RESET_CYCLES + table_q.size() * TIMEOUT_FACTOR) * CLK_PERIOD);
    $display("watchdog: the transfers did not complete in time, the bus seems to hang");
    $display("Regression failed");
    $finish;
  end

endmodule

/* verilog/ahb_addr_decoder.sv */
// ====================
// purely combinational, decodes in the address phase cycle
// SEQ is decoded like NONSEQ, no 1 KB boundary checks
// ====================
`timescale 1ns/10ps

module ahb_addr_decoder (
  input  ahb_fabric_pkg::ahb_req_t   req,
  output ahb_fabric_pkg::slave_sel_t hsel,
  output logic                       default_sel
);

  // NONSEQ or SEQ in the address phase
  logic                       active;
  // raw range hits, not yet qualified by htrans
  ahb_fabric_pkg::slave_sel_t hit;

  assign active = (req.htrans == ahb_fabric_pkg::NONSEQ) ||
                  (req.htrans == ahb_fabric_pkg::SEQ);

  // ====================
  // range compare
  always_comb begin
    hit = '0;
    // slave 0, 1 KB sram
    if ((req.haddr >= ahb_fabric_pkg::SLV0_LOW) &&
        (req.haddr <= ahb_fabric_pkg::SLV0_HIGH)) begin
      hit[0] = 1'b1;
    end
    // slave 1, 256 byte sram
    if ((req.haddr >= ahb_fabric_pkg::SLV1_LOW) &&
        (req.haddr <= ahb_fabric_pkg::SLV1_HIGH)) begin
      hit[1] = 1'b1;
    end
  end

  // ====================
  // select outputs
  // idle and busy select nobody
  assign hsel = active ? hit : '0;

  // active transfer into a hole of the map
  assign default_sel = active && (hit == '0);

endmodule

/* verilog/ahb_data_phase_ctrl.sv */
// ====================
// tracks which slave owns the data phase and returns its answer
// selects are sampled only on edges with hready high
// ====================
`timescale 1ns/10ps

module ahb_data_phase_ctrl (
  input  logic                                                 hclk,
  input  logic                                                 rst,
  input  ahb_fabric_pkg::slave_sel_t                           hsel,
  input  logic                                                 default_sel,
  input  ahb_fabric_pkg::ahb_rsp_t [ahb_fabric_pkg::NUM_SLAVES-1:0] slv_rsp,
  input  ahb_fabric_pkg::ahb_rsp_t                             dflt_rsp,
  output ahb_fabric_pkg::ahb_data_t                            hrdata,
  output logic                                                 hready,
  output ahb_fabric_pkg::hresp_t                               hresp
);

  typedef enum logic [1:0] {
    DP_IDLE,
    DP_SLV0,
    DP_SLV1,
    DP_DEFAULT
  } dp_state_t;

  dp_state_t                dp_state;
  dp_state_t                dp_next;
  // response of the current owner
  ahb_fabric_pkg::ahb_rsp_t sel_rsp;

  // ====================
  // owner of the next data phase
  always_comb begin
    if (hsel[0]) begin
      dp_next = DP_SLV0;
    end else if (hsel[1]) begin
      dp_next = DP_SLV1;
    end else if (default_sel) begin
      dp_next = DP_DEFAULT;
    end else begin
      // idle or busy, no data phase action
      dp_next = DP_IDLE;
    end
  end

  // advance only when the current data phase completes
  always_ff @(posedge hclk) begin
    if (rst) begin
      dp_state <= DP_IDLE;
    end else if (hready) begin
      dp_state <= dp_next;
    end
  end

  // ====================
  // response mux
  always_comb begin
    case (dp_state)
      DP_SLV0:    sel_rsp = slv_rsp[0];
      DP_SLV1:    sel_rsp = slv_rsp[1];
      DP_DEFAULT: sel_rsp = dflt_rsp;
      default: begin
        // zero wait OKAY when nobody owns the phase
        sel_rsp.hrdata    = '0;
        sel_rsp.hreadyout = 1'b1;
        sel_rsp.hresp     = ahb_fabric_pkg::OKAY;
      end
    endcase
  end

  assign hrdata = sel_rsp.hrdata;
  assign hready = sel_rsp.hreadyout;
  assign hresp  = sel_rsp.hresp;

endmodule

/* verilog/ahb_default_slave.sv */
// ====================
// answers unmapped transfers with the two-cycle ERROR response
// read data is always zero, writes are dropped
// ====================
`timescale 1ns/10ps

module ahb_default_slave (
  input  logic                     hclk,
  input  logic                     rst,
  input  logic                     default_sel,
  input  logic                     hready,
  output ahb_fabric_pkg::ahb_rsp_t rsp
);

  // err_wait is the first cycle with hreadyout low,
  // err_last the second with hreadyout high
  typedef enum logic [1:0] {
    DS_IDLE,
    DS_ERR_WAIT,
    DS_ERR_LAST
  } ds_state_t;

  ds_state_t state;

  // ====================
  // error sequence
  always_ff @(posedge hclk) begin
    if (rst) begin
      state <= DS_IDLE;
    end else if (hready) begin
      // new address phase accepted, ours or not
      state <= default_sel ? DS_ERR_WAIT : DS_IDLE;
    end else if (state == DS_ERR_WAIT) begin
      // we hold hready low ourselves
      state <= DS_ERR_LAST;
    end
  end

  // ====================
  // response
  assign rsp.hrdata    = '0;
  assign rsp.hreadyout = (state != DS_ERR_WAIT);
  // ERROR must be seen for both cycles
  assign rsp.hresp     = (state == DS_IDLE) ? ahb_fabric_pkg::OKAY :
                                              ahb_fabric_pkg::ERROR;

endmodule

/* verilog/ahb_fabric_pkg.sv */
// ====================
// shared types and address map for the single-master AHB-Lite fabric
// word transfers only; hsize, hprot, split and retry are not carried
// ====================
package ahb_fabric_pkg;

  // ====================
  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] ahb_addr_t;
  typedef logic [DATA_W-1:0] ahb_data_t;

  // ====================
  // address map
  // two sram slaves, anything else goes to the default slave
  localparam int NUM_SLAVES = 2;

  // one-hot, bit n selects sram slave n
  typedef logic [NUM_SLAVES-1:0] slave_sel_t;

  // inclusive bounds
  localparam ahb_addr_t SLV0_LOW  = 32'h0000_2000;
  localparam ahb_addr_t SLV0_HIGH = 32'h0000_23FF;
  localparam ahb_addr_t SLV1_LOW  = 32'h0000_2400;
  localparam ahb_addr_t SLV1_HIGH = 32'h0000_24FF;

  // depth in 32-bit words
  localparam int SLV0_WORDS = 256;
  localparam int SLV1_WORDS = 64;

  // ====================
  // transfer and response encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // split and retry dropped, so one bit is enough
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  // address phase from the master, 35 bits
  typedef struct packed {
    ahb_addr_t haddr;
    htrans_t   htrans;
    logic      hwrite;
  } ahb_req_t;

  // data phase answer of one slave, 34 bits
  typedef struct packed {
    ahb_data_t hrdata;
    logic      hreadyout;
    hresp_t    hresp;
  } ahb_rsp_t;

endpackage

/* verilog/ahb_fabric_top.sv */
// ====================
// single-master AHB-Lite fabric, two srams and a default slave
// slave 0 answers in one cycle, slave 1 and unmapped in two
// ====================
`timescale 1ns/10ps

module ahb_fabric_top (
  input  logic                      hclk,
  input  logic                      rst,
  input  ahb_fabric_pkg::ahb_req_t  req,
  input  ahb_fabric_pkg::ahb_data_t hwdata,
  output ahb_fabric_pkg::ahb_data_t hrdata,
  output logic                      hready,
  output ahb_fabric_pkg::hresp_t    hresp
);

  ahb_fabric_pkg::slave_sel_t                               hsel;
  logic                                                     default_sel;
  ahb_fabric_pkg::ahb_rsp_t [ahb_fabric_pkg::NUM_SLAVES-1:0] slv_rsp;
  ahb_fabric_pkg::ahb_rsp_t                                 dflt_rsp;

  // ====================
  // address phase decode
  ahb_addr_decoder u_decoder (
    .req         (req),
    .hsel        (hsel),
    .default_sel (default_sel)
  );

  // ====================
  // slaves
  // 1 KB, no wait states
  ahb_sram_slave #(
    .WORDS       (ahb_fabric_pkg::SLV0_WORDS),
    .WAIT_STATES (0)
  ) u_sram0 (
    .hclk   (hclk),
    .rst    (rst),
    .hsel   (hsel[0]),
    .req    (req),
    .hready (hready),
    .hwdata (hwdata),
    .rsp    (slv_rsp[0])
  );

  // 256 bytes, one wait state
  ahb_sram_slave #(
    .WORDS       (ahb_fabric_pkg::SLV1_WORDS),
    .WAIT_STATES (1)
  ) u_sram1 (
    .hclk   (hclk),
    .rst    (rst),
    .hsel   (hsel[1]),
    .req    (req),
    .hready (hready),
    .hwdata (hwdata),
    .rsp    (slv_rsp[1])
  );

  ahb_default_slave u_default_slave (
    .hclk        (hclk),
    .rst         (rst),
    .default_sel (default_sel),
    .hready      (hready),
    .rsp         (dflt_rsp)
  );

  // data phase owner and response back to the master
  ahb_data_phase_ctrl u_data_phase_ctrl (
    .hclk        (hclk),
    .rst         (rst),
    .hsel        (hsel),
    .default_sel (default_sel),
    .slv_rsp     (slv_rsp),
    .dflt_rsp    (dflt_rsp),
    .hrdata      (hrdata),
    .hready      (hready),
    .hresp       (hresp)
  );

endmodule

/* verilog/ahb_sram_slave.sv */
// ====================
// word-wide sram slave, always answers OKAY
// WORDS must be a power of two, the word index wraps within it
// read data comes straight from the array on the last data phase cycle
// ====================
`timescale 1ns/10ps

module ahb_sram_slave #(
  parameter int WORDS       = 256,
  parameter int WAIT_STATES = 0
) (
  input  logic                      hclk,
  input  logic                      rst,
  input  logic                      hsel,
  input  ahb_fabric_pkg::ahb_req_t  req,
  input  logic                      hready,
  input  ahb_fabric_pkg::ahb_data_t hwdata,
  output ahb_fabric_pkg::ahb_rsp_t  rsp
);

  localparam int IDX_W = $clog2(WORDS);
  // at least one bit even with no wait states
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  ahb_fabric_pkg::ahb_data_t mem [WORDS];

  // data phase owned by this slave
  logic             active;
  // wait states still to insert
  logic [CNT_W-1:0] wait_cnt;
  // latched address phase
  logic             write_q;
  logic [IDX_W-1:0] idx_q;
  // final cycle of the data phase
  logic             last_cycle;

  // ====================
  // data phase control
  always_ff @(posedge hclk) begin
    if (rst) begin
      active   <= 1'b0;
      wait_cnt <= '0;
    end else if (hready) begin
      // previous phase ends here, maybe a new one starts
      active   <= hsel;
      wait_cnt <= hsel ? CNT_W'(WAIT_STATES) : '0;
    end else if (active && (wait_cnt != '0)) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // address and direction of the accepted transfer
  always_ff @(posedge hclk) begin
    if (hready && hsel) begin
      // byte address to word index
      idx_q   <= req.haddr[IDX_W+1:2];
      write_q <= req.hwrite;
    end
  end

  assign last_cycle = active && (wait_cnt == '0);

  // ====================
  // storage
  // hwdata is valid for the whole data phase, commit on its last edge
  always_ff @(posedge hclk) begin
    if (last_cycle && write_q) begin
      mem[idx_q] <= hwdata;
    end
  end

  // response
  always_comb begin
    rsp.hrdata    = '0;
    // ready when idle or done waiting
    rsp.hreadyout = !active || last_cycle;
    rsp.hresp     = ahb_fabric_pkg::OKAY;
    if (last_cycle && !write_q) begin
      rsp.hrdata = mem[idx_q];
    end
  end

endmodule
